// File: bench/tb_decode_ref.svh
// Expected results for the decode stage, built from the decode rules.
// Included inside the testbench module after the mips_pkg import.
// Register values are passed in from the testbench shadow copy.
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

`include "mips_consts.svh"

typedef struct packed {
	logic taken;
	jump_kind_e kind;
	logic [`MIPS_XLEN-1:0] br_tgt;
	logic [`MIPS_XLEN-1:0] j_tgt;
} br_exp_t;

// ========================================
// ID/EX bundle
// ========================================
function automatic id_ex_t ref_id_ex(input logic [31:0] iw, input logic [31:0] p4,
		input logic [31:0] rs_val, input logic [31:0] rt_val);
	id_ex_t e;
	logic [5:0] op;
	logic [5:0] fn;
	op = iw[31:26];
	fn = iw[5:0];
	e = '0;
	e.rs_data = rs_val;
	e.rt_data = rt_val;
	e.rs_addr = iw[25:21];
	e.rt_addr = iw[20:16];
	e.rd_addr = iw[15:11];
	e.pc4 = p4;
	e.imm_ext = {{16{iw[15]}}, iw[15:0]};
	case (op)
		`OP_RTYPE: begin
			case (fn)
				`FN_ADD, `FN_ADDU: e.ex.alu_op = ALU_ADD;
				`FN_SUB: e.ex.alu_op = ALU_SUB;
				`FN_AND: e.ex.alu_op = ALU_AND;
				`FN_OR: e.ex.alu_op = ALU_OR;
				`FN_SLT: e.ex.alu_op = ALU_SLT;
				`FN_JALR: begin
					e.ex.alu_op = ALU_PC4;
					e.ex.alu_pc4 = 1'b1;
				end
				default: ;
			endcase
			// jr and unknown functions leave everything off
			if (e.ex.alu_op != ALU_NOP) begin
				e.ex.reg_dst = 1'b1;
				e.wb.reg_write = 1'b1;
			end
		end
		`OP_ADDI, `OP_ADDIU: e.ex.alu_op = ALU_ADD;
		`OP_SLTI: e.ex.alu_op = ALU_SLT;
		`OP_ANDI: begin
			e.ex.alu_op = ALU_AND;
			e.imm_ext = {16'h0000, iw[15:0]};
		end
		`OP_ORI: begin
			e.ex.alu_op = ALU_OR;
			e.imm_ext = {16'h0000, iw[15:0]};
		end
		`OP_LUI: begin
			e.ex.alu_op = ALU_LUI;
			e.imm_ext = {iw[15:0], 16'h0000};
		end
		`OP_LW, `OP_LB, `OP_LBU: begin
			e.ex.alu_op = ALU_ADD;
			e.mem.mem_read = 1'b1;
			e.wb.mem_to_reg = 1'b1;
			if (op == `OP_LB) begin
				e.wb.load_kind = LD_BYTE;
			end else if (op == `OP_LBU) begin
				e.wb.load_kind = LD_UBYTE;
			end
		end
		`OP_SW: begin
			e.ex.alu_op = ALU_ADD;
			e.mem.mem_write = 1'b1;
		end
		`OP_JAL: begin
			e.ex.alu_op = ALU_PC4;
			e.ex.reg_dst = 1'b1;
			e.ex.alu_pc4 = 1'b1;
			e.wb.reg_write = 1'b1;
			e.rd_addr = 5'd31;
		end
		default: ;
	endcase
	// every immediate-operand instruction
	if (op != `OP_RTYPE && op != `OP_JAL && e.ex.alu_op != ALU_NOP) begin
		e.ex.alu_src = 1'b1;
	end
	if (op != `OP_RTYPE && op != `OP_JAL && op != `OP_SW && e.ex.alu_op != ALU_NOP) begin
		e.wb.reg_write = 1'b1;
	end
	return e;
endfunction

// ========================================
// branch and jump
// ========================================
function automatic br_exp_t ref_branch(input logic [31:0] iw, input logic [31:0] p4,
		input logic [31:0] rs_val, input logic [31:0] rt_val);
	br_exp_t r;
	r = '0;
	r.br_tgt = p4 + ({{16{iw[15]}}, iw[15:0]} << 2);
	r.j_tgt = {p4[31:28], iw[25:0], 2'b00};
	case (iw[31:26])
		`OP_BEQ: r.taken = (rs_val == rt_val);
		`OP_BNE: r.taken = (rs_val != rt_val);
		`OP_BLEZ: r.taken = ($signed(rs_val) <= 32'sd0);
		`OP_BGTZ: r.taken = ($signed(rs_val) > 32'sd0);
		// rt bit 0 picks bgez over bltz
		`OP_REGIMM: r.taken = iw[16] ? ($signed(rs_val) >= 32'sd0) : ($signed(rs_val) < 32'sd0);
		`OP_J, `OP_JAL: r.kind = JMP_TARGET;
		`OP_RTYPE: begin
			if (iw[5:0] == `FN_JR || iw[5:0] == `FN_JALR) begin
				r.kind = JMP_REG;
			end
		end
		default: ;
	endcase
	return r;
endfunction

`endif

// File: bench/tb_decode.sv
// Testbench for the MIPS decode stage.
// Inputs change on the rising edge, outputs are compared on the falling edge.
// The ID/EX bundle is checked one cycle after its instruction.
`timescale 1ns/10ps
`include "mips_consts.svh"

module tb_decode;

	import mips_pkg::*;

	`include "tb_decode_ref.svh"

	localparam int CLK_PERIOD = 4;
	localparam int N_REG_RAND = 48;
	localparam int N_CTRL_OPS = 30;
	localparam int N_CTRL_REP = 3;
	localparam int N_IMM = 8;
	localparam int N_JMP = 8;
	// every test ends with two drain cycles
	localparam int TOTAL_CYC = 5 + (35 + N_REG_RAND) + (N_CTRL_OPS * N_CTRL_REP + 2)
		+ (6 * N_IMM + 2) + 80 + (4 * N_JMP + 2);
	localparam int WATCHDOG_NS = (TOTAL_CYC + 100) * CLK_PERIOD;
	localparam logic [31:0] NOP = 32'h0000_0000;

	// {opcode, function} pairs, the last five are not in the subset
	localparam logic [11:0] CTRL_OPS [N_CTRL_OPS] = '{
		{`OP_RTYPE, `FN_ADD}, {`OP_RTYPE, `FN_ADDU}, {`OP_RTYPE, `FN_SUB},
		{`OP_RTYPE, `FN_AND}, {`OP_RTYPE, `FN_OR}, {`OP_RTYPE, `FN_SLT},
		{`OP_RTYPE, `FN_JR}, {`OP_RTYPE, `FN_JALR}, {`OP_ADDI, 6'h00},
		{`OP_ADDIU, 6'h00}, {`OP_SLTI, 6'h00}, {`OP_ANDI, 6'h00}, {`OP_ORI, 6'h00},
		{`OP_LUI, 6'h00}, {`OP_LW, 6'h00}, {`OP_LB, 6'h00}, {`OP_LBU, 6'h00},
		{`OP_SW, 6'h00}, {`OP_BEQ, 6'h00}, {`OP_BNE, 6'h00}, {`OP_BLEZ, 6'h00},
		{`OP_BGTZ, 6'h00}, {`OP_REGIMM, 6'h00}, {`OP_J, 6'h00}, {`OP_JAL, 6'h00},
		{`OP_RTYPE, 6'h00}, {`OP_RTYPE, 6'h27}, {6'h0b, 6'h00}, {6'h10, 6'h00},
		{6'h3f, 6'h00}
	};

	logic clk;
	logic nrst;
	logic [31:0] instr;
	logic [31:0] pc4;
	logic wb_we;
	logic [4:0] wb_addr;
	logic [31:0] wb_data;
	logic branch_taken;
	jump_kind_e jump_kind;
	logic [31:0] branch_target;
	logic [31:0] jump_target;
	id_ex_t id_ex;

	logic [31:0] shadow [32];
	id_ex_t exp_q [$];
	integer seed;
	int check_count;
	int err_count;
	int checks_before;
	int errs_before;

	decode_stage uut (
		.i_clk           (clk),
		.i_nrst          (nrst),
		.i_instr         (instr),
		.i_pc4           (pc4),
		.i_wb_we         (wb_we),
		.i_wb_addr       (wb_addr),
		.i_wb_data       (wb_data),
		.o_branch_taken  (branch_taken),
		.o_jump_kind     (jump_kind),
		.o_branch_target (branch_target),
		.o_jump_target   (jump_target),
		.o_id_ex         (id_ex)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ========================================
	// compare tasks
	// ========================================
	task automatic check_id_ex(input id_ex_t got, input id_ex_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[ERROR] o_id_ex at %0t: got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_jump(input jump_kind_e got, input jump_kind_e exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[ERROR] o_jump_kind at %0t: got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[ERROR] %s at %0t: got %h expected %h", name, $time, got, exp);
		end
	endtask

	// comparing process, falling edge so all inputs are settled
	always @(negedge clk) begin : compare_outputs
		br_exp_t bexp;
		id_ex_t iexp;
		if (!nrst) begin
			exp_q.delete();
			check_id_ex(id_ex, '0);
		end else begin
			// empty queue means the first cycle out of reset
			if (exp_q.size() == 0) begin
				iexp = '0;
			end else begin
				iexp = exp_q.pop_front();
			end
			check_id_ex(id_ex, iexp);
			bexp = ref_branch(instr, pc4, shadow[instr[25:21]], shadow[instr[20:16]]);
			check_addr("o_branch_taken", {31'b0, branch_taken}, {31'b0, bexp.taken});
			check_jump(jump_kind, bexp.kind);
			check_addr("o_branch_target", branch_target, bexp.br_tgt);
			check_addr("o_jump_target", jump_target, bexp.j_tgt);
			exp_q.push_back(ref_id_ex(instr, pc4, shadow[instr[25:21]], shadow[instr[20:16]]));
			// write lands at the next edge, after this read was captured
			if (wb_we && wb_addr != 5'd0) begin
				shadow[wb_addr] = wb_data;
			end
		end
	end

	// ========================================
	// stimulus helpers
	// ========================================
	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	task automatic issue(input logic [31:0] iw, input logic [31:0] p4, input logic we,
			input logic [4:0] wa, input logic [31:0] wd);
		@(posedge clk);
		instr <= iw;
		pc4 <= p4;
		wb_we <= we;
		wb_addr <= wa;
		wb_data <= wd;
	endtask

	// two idle cycles let the last bundle reach the compare
	task automatic finish_test(input string name);
		issue(NOP, 32'h0, 1'b0, 5'd0, 32'h0);
		issue(NOP, 32'h0, 1'b0, 5'd0, 32'h0);
		$display("test %s: %0d checks, %0d errors", name, check_count - checks_before,
			err_count - errs_before);
		checks_before = check_count;
		errs_before = err_count;
	endtask

	// ========================================
	// tests
	// ========================================
	task automatic reg_file_test();
		logic [31:0] r;
		logic [31:0] w;
		for (int a = 1; a < 32; a++) begin
			issue(NOP, 32'h0, 1'b1, a[4:0], rand_word());
		end
		for (int k = 0; k < N_REG_RAND; k++) begin
			r = rand_word();
			w = rand_word();
			issue({`OP_RTYPE, r[25:11], 5'd0, `FN_ADDU}, r & 32'hffff_fffc, 1'b1, w[4:0],
				rand_word());
		end
		issue(NOP, 32'h0, 1'b1, 5'd0, 32'hdead_beef);
		issue({`OP_RTYPE, 5'd0, 5'd0, 5'd2, 5'd0, `FN_ADDU}, 32'h0, 1'b0, 5'd0, 32'h0);
		finish_test("register file");
	endtask

	task automatic control_test();
		logic [31:0] r;
		for (int rep = 0; rep < N_CTRL_REP; rep++) begin
			for (int k = 0; k < N_CTRL_OPS; k++) begin
				r = rand_word();
				if (CTRL_OPS[k][11:6] == `OP_RTYPE) begin
					issue({`OP_RTYPE, r[25:6], CTRL_OPS[k][5:0]}, r & 32'hffff_fffc, 1'b0,
						5'd0, 32'h0);
				end else begin
					issue({CTRL_OPS[k][11:6], r[25:0]}, r & 32'hffff_fffc, 1'b0, 5'd0, 32'h0);
				end
			end
		end
		finish_test("control decode");
	endtask

	task automatic immediate_test();
		logic [5:0] ops [6];
		logic [31:0] r;
		ops = '{`OP_ADDI, `OP_ANDI, `OP_ORI, `OP_LUI, `OP_LW, `OP_SW};
		for (int k = 0; k < 6; k++) begin
			for (int n = 0; n < N_IMM; n++) begin
				r = rand_word();
				issue({ops[k], r[25:0]}, 32'h0000_1000, 1'b0, 5'd0, 32'h0);
			end
		end
		finish_test("immediate");
	endtask

	task automatic branch_test();
		logic [31:0] vals [6];
		logic [5:0] ops [6];
		logic [31:0] r;
		int rt;
		// zero, positive, negative and the signed extremes
		vals = '{32'h0, 32'h5, 32'hffff_fff9, 32'h5, 32'h8000_0000, 32'h7fff_ffff};
		ops = '{`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_REGIMM, `OP_REGIMM};
		for (int a = 0; a < 6; a++) begin
			issue(NOP, 32'h0, 1'b1, 5'(a + 1), vals[a]);
		end
		for (int k = 0; k < 6; k++) begin
			for (int rs = 1; rs <= 6; rs++) begin
				for (int n = 0; n < 2; n++) begin
					r = rand_word();
					rt = (n == 0) ? rs : (rs % 6) + 1;
					// bltz has rt 0, bgez has rt 1
					if (k >= 4) begin
						rt = k - 4;
					end
					issue({ops[k], 5'(rs), 5'(rt), r[15:0]}, rand_word() & 32'hffff_fffc,
						1'b0, 5'd0, 32'h0);
				end
			end
		end
		finish_test("branch");
	endtask

	task automatic jump_test();
		logic [31:0] r;
		for (int n = 0; n < N_JMP; n++) begin
			r = rand_word();
			issue({`OP_J, r[25:0]}, rand_word() & 32'hffff_fffc, 1'b0, 5'd0, 32'h0);
			r = rand_word();
			issue({`OP_JAL, r[25:0]}, rand_word() & 32'hffff_fffc, 1'b0, 5'd0, 32'h0);
			r = rand_word();
			issue({`OP_RTYPE, r[25:6], `FN_JR}, rand_word() & 32'hffff_fffc, 1'b0, 5'd0, 32'h0);
			r = rand_word();
			issue({`OP_RTYPE, r[25:6], `FN_JALR}, rand_word() & 32'hffff_fffc, 1'b0, 5'd0,
				32'h0);
		end
		finish_test("jump");
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		seed = 32'hf149_4adb;
		check_count = 0;
		err_count = 0;
		checks_before = 0;
		errs_before = 0;
		for (int a = 0; a < 32; a++) begin
			shadow[a] = 32'h0;
		end
		nrst <= 1'b0;
		instr <= NOP;
		pc4 <= 32'h0;
		wb_we <= 1'b0;
		wb_addr <= 5'd0;
		wb_data <= 32'h0;
		repeat (3) @(posedge clk);
		nrst <= 1'b1;
		finish_test("reset");
		reg_file_test();
		control_test();
		immediate_test();
		branch_test();
		jump_test();
		$display("summary: %0d checks, %0d errors", check_count, err_count);
		if (err_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// watchdog sized from the stimulus length
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: stimulus did not complete within %0d ns", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+hdl
+incdir+bench
hdl/mips_pkg.sv
hdl/reg_bank.sv
hdl/main_control.sv
hdl/branch_unit.sv
hdl/imm_target_gen.sv
hdl/decode_stage.sv
bench/tb_decode.sv

// File: hdl/branch_unit.sv
// Branch and jump resolution in decode.
// Conditions use signed compares of the raw register values; no forwarding,
// so the operands must already be in the register file.
`timescale 1ns/10ps
`include "mips_consts.svh"

module branch_unit (
	input  mips_pkg::instr_u      i_instr,
	input  logic [`MIPS_XLEN-1:0] i_rs_data,
	input  logic [`MIPS_XLEN-1:0] i_rt_data,
	output logic                  o_taken,
	output mips_pkg::jump_kind_e  o_jump_kind,
	output logic                  o_link
);

	import mips_pkg::*;

	branch_op_e br_op;
	logic is_jr_fn;
	logic is_jalr_fn;
	logic signed [`MIPS_XLEN-1:0] rs_s;

	assign rs_s = $signed(i_rs_data);

	// register jumps are R-type with the jr or jalr function
	assign is_jr_fn = (i_instr.r.op == `OP_RTYPE) && (i_instr.r.funct == `FN_JR);
	assign is_jalr_fn = (i_instr.r.op == `OP_RTYPE) && (i_instr.r.funct == `FN_JALR);

	// ========================================
	// branch kind
	// ========================================
	always_comb begin
		case (i_instr.i.op)
			`OP_BEQ: br_op = BR_EQ;
			`OP_BNE: br_op = BR_NE;
			`OP_BLEZ: br_op = BR_LEZ;
			`OP_BGTZ: br_op = BR_GTZ;
			// bltz when rt[0] is 0, bgez when 1
			`OP_REGIMM: br_op = i_instr.i.rt[0] ? BR_GEZ : BR_LTZ;
			default: br_op = BR_NONE;
		endcase
	end

	// ========================================
	// condition
	// ========================================
	always_comb begin
		case (br_op)
			BR_EQ: o_taken = (i_rs_data == i_rt_data);
			BR_NE: o_taken = (i_rs_data != i_rt_data);
			BR_LEZ: o_taken = (rs_s <= 0);
			BR_GTZ: o_taken = (rs_s > 0);
			BR_LTZ: o_taken = (rs_s < 0);
			BR_GEZ: o_taken = (rs_s >= 0);
			default: o_taken = 1'b0;
		endcase
	end

	// ========================================
	// jumps
	// ========================================
	always_comb begin
		if (i_instr.j.op == `OP_J || i_instr.j.op == `OP_JAL) begin
			o_jump_kind = JMP_TARGET;
		end else if (is_jr_fn || is_jalr_fn) begin
			o_jump_kind = JMP_REG;
		end else begin
			o_jump_kind = JMP_NONE;
		end
	end

	assign o_link = (i_instr.j.op == `OP_JAL) || is_jalr_fn;

endmodule

// File: hdl/decode_stage.sv
// Decode stage of the five-stage MIPS pipeline.
// Branch and jump outputs are combinational in the decode cycle; everything
// for execute is registered in o_id_ex one clock later. No stalls or flushes.
// The writeback port writes the register file directly.
`timescale 1ns/10ps
`include "mips_consts.svh"

module decode_stage (
	input  logic                     i_clk,
	input  logic                     i_nrst,
	input  logic [`MIPS_XLEN-1:0]    i_instr,
	input  logic [`MIPS_XLEN-1:0]    i_pc4,
	input  logic                     i_wb_we,
	input  logic [`MIPS_RADDR_W-1:0] i_wb_addr,
	input  logic [`MIPS_XLEN-1:0]    i_wb_data,
	output logic                     o_branch_taken,
	output mips_pkg::jump_kind_e     o_jump_kind,
	output logic [`MIPS_XLEN-1:0]    o_branch_target,
	output logic [`MIPS_XLEN-1:0]    o_jump_target,
	output mips_pkg::id_ex_t         o_id_ex
);

	import mips_pkg::*;

	// jal links into $ra
	localparam logic [`MIPS_RADDR_W-1:0] RA_REG = `MIPS_RADDR_W'(31);

	instr_u instr;
	logic [`MIPS_XLEN-1:0] rs_data;
	logic [`MIPS_XLEN-1:0] rt_data;
	ex_ctrl_t ex_ctrl;
	mem_ctrl_t mem_ctrl;
	wb_ctrl_t wb_ctrl;
	ext_mode_e ext_mode;
	logic link;
	logic [`MIPS_XLEN-1:0] imm_ext;
	id_ex_t id_ex_d;

	assign instr = instr_u'(i_instr);

	// ========================================
	// blocks
	// ========================================
	reg_bank u_reg_bank (
		.i_clk     (i_clk),
		.i_nrst    (i_nrst),
		.i_rs_addr (instr.r.rs),
		.i_rt_addr (instr.r.rt),
		.i_we      (i_wb_we),
		.i_wr_addr (i_wb_addr),
		.i_wr_data (i_wb_data),
		.o_rs_data (rs_data),
		.o_rt_data (rt_data)
	);

	main_control u_main_control (
		.i_instr    (instr),
		.o_ex       (ex_ctrl),
		.o_mem      (mem_ctrl),
		.o_wb       (wb_ctrl),
		.o_ext_mode (ext_mode)
	);

	branch_unit u_branch_unit (
		.i_instr     (instr),
		.i_rs_data   (rs_data),
		.i_rt_data   (rt_data),
		.o_taken     (o_branch_taken),
		.o_jump_kind (o_jump_kind),
		.o_link      (link)
	);

	imm_target_gen u_imm_target_gen (
		.i_instr         (instr),
		.i_ext_mode      (ext_mode),
		.i_pc4           (i_pc4),
		.o_imm_ext       (imm_ext),
		.o_branch_target (o_branch_target),
		.o_jump_target   (o_jump_target)
	);

	// ========================================
	// ID/EX register
	// ========================================
	always_comb begin
		id_ex_d.ex = ex_ctrl;
		id_ex_d.ex.alu_pc4 = link;
		id_ex_d.mem = mem_ctrl;
		id_ex_d.wb = wb_ctrl;
		id_ex_d.rs_data = rs_data;
		id_ex_d.rt_data = rt_data;
		id_ex_d.rs_addr = instr.r.rs;
		id_ex_d.rt_addr = instr.r.rt;
		// link with a target jump is jal, jalr keeps rd
		if (link && o_jump_kind == JMP_TARGET) begin
			id_ex_d.rd_addr = RA_REG;
		end else begin
			id_ex_d.rd_addr = instr.r.rd;
		end
		id_ex_d.pc4 = i_pc4;
		id_ex_d.imm_ext = imm_ext;
	end

	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			o_id_ex <= '0;
		end else begin
			o_id_ex <= id_ex_d;
		end
	end

	// writeback enable downstream must always be defined
	a_wb_known: assert property (
		@(posedge i_clk) disable iff (!i_nrst)
		!$isunknown(o_id_ex.wb.reg_write)
	) else $error("decode_stage: reg_write in ID/EX is unknown");

endmodule

// File: hdl/imm_target_gen.sv
// Immediate extension plus branch and jump target arithmetic.
// Branch target is relative to pc4; the jump target keeps the pc4 segment.
`timescale 1ns/10ps
`include "mips_consts.svh"

module imm_target_gen (
	input  mips_pkg::instr_u      i_instr,
	input  mips_pkg::ext_mode_e   i_ext_mode,
	input  logic [`MIPS_XLEN-1:0] i_pc4,
	output logic [`MIPS_XLEN-1:0] o_imm_ext,
	output logic [`MIPS_XLEN-1:0] o_branch_target,
	output logic [`MIPS_XLEN-1:0] o_jump_target
);

	import mips_pkg::*;

	logic [`MIPS_XLEN-1:0] imm_sx;

	assign imm_sx = {{16{i_instr.i.imm[15]}}, i_instr.i.imm};

	// extension by mode
	always_comb begin
		case (i_ext_mode)
			EXT_ZERO: o_imm_ext = {16'h0000, i_instr.i.imm};
			EXT_UPPER: o_imm_ext = {i_instr.i.imm, 16'h0000};
			default: o_imm_ext = imm_sx;
		endcase
	end

	// word offset, always sign extended whatever the mode
	assign o_branch_target = i_pc4 + {imm_sx[`MIPS_XLEN-3:0], 2'b00};

	assign o_jump_target = {i_pc4[`MIPS_XLEN-1:28], i_instr.j.target, 2'b00};

endmodule

// File: hdl/main_control.sv
// Main decoder for the supported MIPS subset.
// alu_pc4 is always low here; the top merges the link flag from branch_unit.
// Unknown opcodes and function codes give all-zero control.
`timescale 1ns/10ps
`include "mips_consts.svh"

module main_control (
	input  mips_pkg::instr_u    i_instr,
	output mips_pkg::ex_ctrl_t  o_ex,
	output mips_pkg::mem_ctrl_t o_mem,
	output mips_pkg::wb_ctrl_t  o_wb,
	output mips_pkg::ext_mode_e o_ext_mode
);

	import mips_pkg::*;

	always_comb begin
		o_ex = '0;
		o_mem = '0;
		o_wb = '0;
		o_ext_mode = EXT_SIGN;

		case (i_instr.r.op)
			`OP_RTYPE: begin
				o_ex.reg_dst = 1'b1;
				o_wb.reg_write = 1'b1;
				case (i_instr.r.funct)
					`FN_ADD, `FN_ADDU: o_ex.alu_op = ALU_ADD;
					`FN_SUB: o_ex.alu_op = ALU_SUB;
					`FN_AND: o_ex.alu_op = ALU_AND;
					`FN_OR: o_ex.alu_op = ALU_OR;
					`FN_SLT: o_ex.alu_op = ALU_SLT;
					// link into rd
					`FN_JALR: o_ex.alu_op = ALU_PC4;
					// jr and unknown functions write nothing
					default: begin
						o_ex.reg_dst = 1'b0;
						o_wb.reg_write = 1'b0;
					end
				endcase
			end
			`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_LUI: begin
				o_ex.alu_src = 1'b1;
				o_wb.reg_write = 1'b1;
				case (i_instr.i.op)
					`OP_SLTI: o_ex.alu_op = ALU_SLT;
					`OP_ANDI: o_ex.alu_op = ALU_AND;
					`OP_ORI: o_ex.alu_op = ALU_OR;
					`OP_LUI: o_ex.alu_op = ALU_LUI;
					default: o_ex.alu_op = ALU_ADD;
				endcase
				if (i_instr.i.op == `OP_ANDI || i_instr.i.op == `OP_ORI) begin
					o_ext_mode = EXT_ZERO;
				end else if (i_instr.i.op == `OP_LUI) begin
					o_ext_mode = EXT_UPPER;
				end
			end
			`OP_LW, `OP_LB, `OP_LBU: begin
				o_ex.alu_op = ALU_ADD;
				o_ex.alu_src = 1'b1;
				o_mem.mem_read = 1'b1;
				o_wb.mem_to_reg = 1'b1;
				o_wb.reg_write = 1'b1;
				if (i_instr.i.op == `OP_LB) begin
					o_wb.load_kind = LD_BYTE;
				end else if (i_instr.i.op == `OP_LBU) begin
					o_wb.load_kind = LD_UBYTE;
				end
			end
			`OP_SW: begin
				o_ex.alu_op = ALU_ADD;
				o_ex.alu_src = 1'b1;
				o_mem.mem_write = 1'b1;
			end
			// destination 31 is chosen at the top
			`OP_JAL: begin
				o_ex.alu_op = ALU_PC4;
				o_ex.reg_dst = 1'b1;
				o_wb.reg_write = 1'b1;
			end
			// branches and j need no execute or writeback control
			default: ;
		endcase
	end

	always_comb begin
		a_mem_excl: assert (!(o_mem.mem_read && o_mem.mem_write))
			else $error("main_control: load and store strobes both high");
	end

endmodule

// File: hdl/mips_consts.svh
// Widths, register count and MIPS encodings shared by the decode stage.
// Opcodes and function codes follow the standard MIPS I numbering.
// Only the decoded subset is listed here.
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// ========================================
// widths
// ========================================
`define MIPS_XLEN 32
`define MIPS_NREG 32
`define MIPS_RADDR_W 5

// ========================================
// opcodes, instr[31:26]
// ========================================
`define OP_RTYPE 6'h00
`define OP_REGIMM 6'h01
`define OP_J 6'h02
`define OP_JAL 6'h03
`define OP_BEQ 6'h04
`define OP_BNE 6'h05
`define OP_BLEZ 6'h06
`define OP_BGTZ 6'h07
`define OP_ADDI 6'h08
`define OP_ADDIU 6'h09
`define OP_SLTI 6'h0a
`define OP_ANDI 6'h0c
`define OP_ORI 6'h0d
`define OP_LUI 6'h0f
`define OP_LB 6'h20
`define OP_LW 6'h23
`define OP_LBU 6'h24
`define OP_SW 6'h2b

// ========================================
// function codes for R-type, instr[5:0]
// ========================================
`define FN_JR 6'h08
`define FN_JALR 6'h09
`define FN_ADD 6'h20
`define FN_ADDU 6'h21
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR 6'h25
`define FN_SLT 6'h2a

`endif

// File: hdl/mips_pkg.sv
// Types shared by the decode stage blocks and by the execute side.
// Every encoding with value zero is the inactive one, so an all-zero
// pipeline register is a bubble.
`include "mips_consts.svh"

package mips_pkg;

	// ========================================
	// instruction layouts
	// ========================================
	typedef struct packed {
		logic [5:0] op;
		logic [`MIPS_RADDR_W-1:0] rs;
		logic [`MIPS_RADDR_W-1:0] rt;
		logic [`MIPS_RADDR_W-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0] op;
		logic [`MIPS_RADDR_W-1:0] rs;
		logic [`MIPS_RADDR_W-1:0] rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0] op;
		logic [25:0] target;
	} j_fmt_t;

	// one word, read as R, I or J format depending on the block
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_u;

	// ========================================
	// encodings
	// ========================================
	typedef enum logic [5:0] {
		ALU_NOP = 6'd0,
		ALU_ADD = 6'd1,
		ALU_SUB = 6'd2,
		ALU_AND = 6'd3,
		ALU_OR = 6'd4,
		ALU_SLT = 6'd5,
		ALU_LUI = 6'd6,
		// pass pc4 through for jal and jalr
		ALU_PC4 = 6'd7
	} alu_op_e;

	typedef enum logic [1:0] {LD_WORD = 2'd0, LD_BYTE = 2'd1, LD_UBYTE = 2'd2} load_kind_e;

	typedef enum logic [1:0] {EXT_SIGN = 2'd0, EXT_ZERO = 2'd1, EXT_UPPER = 2'd2} ext_mode_e;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_EQ = 3'd1,
		BR_NE = 3'd2,
		BR_LEZ = 3'd3,
		BR_GTZ = 3'd4,
		BR_LTZ = 3'd5,
		BR_GEZ = 3'd6
	} branch_op_e;

	typedef enum logic [1:0] {JMP_NONE = 2'd0, JMP_TARGET = 2'd1, JMP_REG = 2'd2} jump_kind_e;

	// ========================================
	// control bundles
	// ========================================
	typedef struct packed {
		alu_op_e alu_op;
		logic alu_src;
		logic reg_dst;
		logic alu_pc4;
	} ex_ctrl_t;

	typedef struct packed {
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	typedef struct packed {
		load_kind_e load_kind;
		logic mem_to_reg;
		logic reg_write;
	} wb_ctrl_t;

	typedef struct packed {
		ex_ctrl_t ex;
		mem_ctrl_t mem;
		wb_ctrl_t wb;
		logic [`MIPS_XLEN-1:0] rs_data;
		logic [`MIPS_XLEN-1:0] rt_data;
		logic [`MIPS_RADDR_W-1:0] rs_addr;
		logic [`MIPS_RADDR_W-1:0] rt_addr;
		logic [`MIPS_RADDR_W-1:0] rd_addr;
		logic [`MIPS_XLEN-1:0] pc4;
		logic [`MIPS_XLEN-1:0] imm_ext;
	} id_ex_t;

endpackage

// File: hdl/reg_bank.sv
// 32 x 32 register file, two combinational read ports, one write port.
// Reads have no write-through; a write is seen from the edge it lands on.
// Register 0 is never written, so it reads as zero after reset.
`timescale 1ns/10ps
`include "mips_consts.svh"

module reg_bank (
	input  logic                     i_clk,
	input  logic                     i_nrst,
	input  logic [`MIPS_RADDR_W-1:0] i_rs_addr,
	input  logic [`MIPS_RADDR_W-1:0] i_rt_addr,
	input  logic                     i_we,
	input  logic [`MIPS_RADDR_W-1:0] i_wr_addr,
	input  logic [`MIPS_XLEN-1:0]    i_wr_data,
	output logic [`MIPS_XLEN-1:0]    o_rs_data,
	output logic [`MIPS_XLEN-1:0]    o_rt_data
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_NREG];

	// write port, register 0 blocked here
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			for (int k = 0; k < `MIPS_NREG; k++) begin
				regs[k] <= '0;
			end
		end else if (i_we && (i_wr_addr != '0)) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	// plain array reads
	assign o_rs_data = regs[i_rs_addr];
	assign o_rt_data = regs[i_rt_addr];

	// entry 0 must stay cleared across every write cycle
	a_zero_reg: assert property (
		@(posedge i_clk) disable iff (!i_nrst)
		(i_rs_addr == '0) |-> (o_rs_data == '0)
	) else $error("reg_bank: register 0 read back nonzero %h", o_rs_data);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_decode -o tb_decode_sim

sim_out=$(./obj_dir/tb_decode_sim)
echo "$sim_out"

if echo "$sim_out" | grep -q "ALL CHECKS PASSED"; then
	exit 0
else
	exit 1
fi
